//--- complexFirPkg.sv
//********************
// Shared types for the complex FIR. Sample and coefficient parts are 8-bit
// two's complement, and results are 21 bits wide, enough for up to 16 taps.
//********************

`default_nettype none

package complexFirPkg;

	// One signed component of an input sample.
	typedef logic signed [7:0] sampleT;

	// One signed component of a filter coefficient.
	typedef logic signed [7:0] coeffT;

	// One signed component of a filter result.
	// A 16-bit product, 1 bit for the complex add and 4 bits of growth over 16 taps.
	typedef logic signed [20:0] accT;

	// Complex input sample, real part in the upper byte.
	typedef struct packed {
		sampleT re;
		sampleT im;
	} complexSampleT;

	// Complex coefficient, real part in the upper byte.
	typedef struct packed {
		coeffT re;
		coeffT im;
	} complexCoeffT;

	// Complex filter result, 42 bits in total.
	typedef struct packed {
		accT re;
		accT im;
	} complexResultT;

	// Control states of the filter core.
	typedef enum logic [1:0] {
		IDLE,
		LOADING,
		RUNNING,
		STOPPED
	} firStateT;

endpackage

`default_nettype wire

//--- coeffSource.sv
//********************
// Streams the built-in coefficient table, one entry per clock, after coeffEnable.
// Entry k is (2k-5) + j(6-3k). A new request must wait for the stream to end.
//********************

`timescale 1ns/1ns
`default_nettype none

module coeffSource import complexFirPkg::*; #(
	parameter int LENGTH = 8
) (
	input  logic         clock,
	input  logic         arstN,
	input  logic         coeffEnable,
	output complexCoeffT coeffOut,
	output logic         coeffValid,
	output logic         coeffDone
);

	// The counter must reach LENGTH itself, so it gets one spare code.
	localparam int IDX_W = $clog2(LENGTH + 1);

	// Index of the next table entry to put on coeffOut.
	logic [IDX_W-1:0] index;

	// The table is fixed, so each entry is computed from its index.
	function automatic complexCoeffT tableEntry(input int k);
		complexCoeffT entry;
		entry.re = coeffT'(2 * k - 5);
		entry.im = coeffT'(6 - 3 * k);
		return entry;
	endfunction

	// Stream control.
	// coeffValid stays high for LENGTH cycles, and coeffDone marks the last one.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			coeffValid <= 1'b0;
			coeffDone <= 1'b0;
			index <= '0;
		end else if (coeffEnable && !coeffValid) begin
			coeffValid <= 1'b1;
			coeffDone <= 1'b0;
			index <= IDX_W'(1);
		end else if (coeffValid) begin
			if (coeffDone) begin
				coeffValid <= 1'b0;
				coeffDone <= 1'b0;
			end else begin
				coeffDone <= (index == IDX_W'(LENGTH - 1));
				index <= index + 1'b1;
			end
		end
	end

	// The entry itself is payload and follows the same schedule as the index.
	always_ff @(posedge clock) begin
		if (coeffEnable && !coeffValid) begin
			coeffOut <= tableEntry(0);
		end else if (coeffValid && !coeffDone) begin
			coeffOut <= tableEntry(int'(index));
		end
	end

	// The core must not ask for a new table while one is still streaming.
	enableWhileActive: assert property (
		@(posedge clock) disable iff (!arstN) coeffEnable |-> !coeffValid
	) else $error("coeffEnable arrived while the coefficient stream was active");

endmodule

`default_nettype wire

//--- complexFirCore.sv
//********************
// Control core of the complex FIR. Strobes are single cycles with no handshake.
// Samples are taken only while ready is high, and a start clears the sample history.
//********************

`timescale 1ns/1ns
`default_nettype none

module complexFirCore import complexFirPkg::*; #(
	parameter int LENGTH = 8
) (
	input  logic                       clock,
	input  logic                       arstN,
	input  logic                       startFlag,
	input  logic                       stopFlag,
	input  logic                       loadDataFlag,
	input  complexSampleT              dataIn,
	input  complexCoeffT               coeffOut,
	input  logic                       coeffValid,
	input  logic                       coeffDone,
	output logic                       coeffEnable,
	output logic                       ready,
	output complexCoeffT  [LENGTH-1:0] tapCoeffs,
	output complexSampleT [LENGTH-1:0] tapSamples,
	output logic                       shiftPulse
);

	firStateT state;

	// A start is honoured only when no load or run is in progress.
	logic startAccept;

	// A sample is taken only while the filter runs.
	logic sampleAccept;

	assign startAccept = startFlag && (state == IDLE || state == STOPPED);
	assign sampleAccept = loadDataFlag && (state == RUNNING);

	// Ready is a plain decode of the state.
	assign ready = (state == RUNNING);

	// State machine and the two control pulses.
	// coeffEnable follows an accepted start by one cycle, and shiftPulse
	// follows an accepted sample by one cycle.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state <= IDLE;
			coeffEnable <= 1'b0;
			shiftPulse <= 1'b0;
		end else begin
			coeffEnable <= startAccept;
			shiftPulse <= sampleAccept;
			case (state)
				IDLE, STOPPED: begin
					if (startFlag) begin
						state <= LOADING;
					end
				end
				LOADING: begin
					// The last coefficient carries coeffDone, so the buffer is full here.
					if (coeffValid && coeffDone) begin
						state <= RUNNING;
					end
				end
				RUNNING: begin
					// A sample in the same cycle is still taken.
					if (stopFlag) begin
						state <= STOPPED;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Coefficient buffer.
	// New entries enter at the top and move down, so entry 0 ends in tap 0
	// after LENGTH shifts.
	always_ff @(posedge clock) begin
		if (coeffValid) begin
			tapCoeffs <= {coeffOut, tapCoeffs[LENGTH-1:1]};
		end
	end

	// Sample delay line.
	// Tap 0 holds the newest sample x[n], and tap k holds x[n-k].
	// A start empties the history so that older samples count as zero.
	always_ff @(posedge clock) begin
		if (startAccept) begin
			tapSamples <= '0;
		end else if (sampleAccept) begin
			tapSamples <= {tapSamples[LENGTH-2:0], dataIn};
		end
	end

	// The source may only stream while the core waits for the table.
	coeffOnlyInLoading: assert property (
		@(posedge clock) disable iff (!arstN) coeffValid |-> state == LOADING
	) else $error("coeffValid seen outside the LOADING state");

	// Beyond 16 taps the 21-bit result can overflow.
	lengthInRange: assert property (
		@(posedge clock) disable iff (!arstN) (LENGTH >= 2) && (LENGTH <= 16)
	) else $error("LENGTH must lie between 2 and 16");

endmodule

`default_nettype wire

//--- complexDotProduct.sv
//********************
// Complex dot product of all taps, registered when shiftPulse is high.
// No rounding or saturation. The sum fits 21 bits for up to 16 taps.
//********************

`timescale 1ns/1ns
`default_nettype none

module complexDotProduct import complexFirPkg::*; #(
	parameter int LENGTH = 8
) (
	input  logic                       clock,
	input  logic                       arstN,
	input  complexCoeffT  [LENGTH-1:0] tapCoeffs,
	input  complexSampleT [LENGTH-1:0] tapSamples,
	input  logic                       shiftPulse,
	output complexResultT              dataOut,
	output logic                       outValid
);

	// Four real partial sums, named after the sample part, then the coefficient part.
	accT sumReRe;
	accT sumImIm;
	accT sumReIm;
	accT sumImRe;

	// Complex result before the output register.
	complexResultT result;

	// Sign extend both factors first so that the product keeps its sign.
	function automatic accT mulPart(input sampleT a, input coeffT b);
		return accT'(a) * accT'(b);
	endfunction

	// Sums over all taps.
	// Tap k pairs x[n-k] with c[k].
	always_comb begin
		sumReRe = '0;
		sumImIm = '0;
		sumReIm = '0;
		sumImRe = '0;
		for (int k = 0; k < LENGTH; k++) begin
			sumReRe += mulPart(tapSamples[k].re, tapCoeffs[k].re);
			sumImIm += mulPart(tapSamples[k].im, tapCoeffs[k].im);
			sumReIm += mulPart(tapSamples[k].re, tapCoeffs[k].im);
			sumImRe += mulPart(tapSamples[k].im, tapCoeffs[k].re);
		end
		// (a + jb)(c + jd) = (ac - bd) + j(ad + bc).
		result.re = sumReRe - sumImIm;
		result.im = sumReIm + sumImRe;
	end

	// The valid pulse follows shiftPulse by one cycle.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= shiftPulse;
		end
	end

	// The result is captured once per accepted sample and held until the next one.
	always_ff @(posedge clock) begin
		if (shiftPulse) begin
			dataOut <= result;
		end
	end

endmodule

`default_nettype wire

//--- complexFirTop.sv
//********************
// Complex FIR with a built-in coefficient table. LENGTH from 2 to 16.
// Give startFlag once, wait for ready, then strobe loadDataFlag per sample.
//********************

`timescale 1ns/1ns
`default_nettype none

module complexFirTop import complexFirPkg::*; #(
	parameter int LENGTH = 8
) (
	input  logic          clock,
	input  logic          arstN,
	input  logic          startFlag,
	input  logic          stopFlag,
	input  logic          loadDataFlag,
	input  complexSampleT dataIn,
	output logic          ready,
	output complexResultT dataOut,
	output logic          outValid
);

	// Coefficient stream between the source and the core.
	logic         coeffEnable;
	complexCoeffT coeffOut;
	logic         coeffValid;
	logic         coeffDone;

	// Tap contents and the shift strobe between the core and the dot product.
	complexCoeffT  [LENGTH-1:0] tapCoeffs;
	complexSampleT [LENGTH-1:0] tapSamples;
	logic                       shiftPulse;

	coeffSource #(
		.LENGTH (LENGTH)
	) coeffSourceInst (
		.clock       (clock),
		.arstN       (arstN),
		.coeffEnable (coeffEnable),
		.coeffOut    (coeffOut),
		.coeffValid  (coeffValid),
		.coeffDone   (coeffDone)
	);

	complexFirCore #(
		.LENGTH (LENGTH)
	) complexFirCoreInst (
		.clock        (clock),
		.arstN        (arstN),
		.startFlag    (startFlag),
		.stopFlag     (stopFlag),
		.loadDataFlag (loadDataFlag),
		.dataIn       (dataIn),
		.coeffOut     (coeffOut),
		.coeffValid   (coeffValid),
		.coeffDone    (coeffDone),
		.coeffEnable  (coeffEnable),
		.ready        (ready),
		.tapCoeffs    (tapCoeffs),
		.tapSamples   (tapSamples),
		.shiftPulse   (shiftPulse)
	);

	complexDotProduct #(
		.LENGTH (LENGTH)
	) complexDotProductInst (
		.clock      (clock),
		.arstN      (arstN),
		.tapCoeffs  (tapCoeffs),
		.tapSamples (tapSamples),
		.shiftPulse (shiftPulse),
		.dataOut    (dataOut),
		.outValid   (outValid)
	);

endmodule

`default_nettype wire

//--- tbComplexFir.sv
//********************
// Testbench for complexFirTop with LENGTH 8. Stops at the first mismatch.
// Expected results come from a model of the coefficient and filter rules.
//********************

`timescale 1ns/1ns
`default_nettype none

module tbComplexFir import complexFirPkg::*; ();

	localparam int LENGTH = 8;
	localparam int READY_LIMIT = LENGTH + 6;
	localparam int DRAIN_LIMIT = 20;

	logic          clock;
	logic          arstN;
	logic          startFlag;
	logic          stopFlag;
	logic          loadDataFlag;
	complexSampleT dataIn;
	logic          ready;
	complexResultT dataOut;
	logic          outValid;

	// The model keeps the last LENGTH accepted samples, newest in slot 0.
	int            histRe [LENGTH];
	int            histIm [LENGTH];
	complexResultT expectedQ [$];
	complexResultT expectedValue;
	int            seed;
	logic          running;
	string         testName;

	complexFirTop #(
		.LENGTH (LENGTH)
	) uut (
		.clock        (clock),
		.arstN        (arstN),
		.startFlag    (startFlag),
		.stopFlag     (stopFlag),
		.loadDataFlag (loadDataFlag),
		.dataIn       (dataIn),
		.ready        (ready),
		.dataOut      (dataOut),
		.outValid     (outValid)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic reportFailure(input string what);
		$display("%s", what);
		$display("Finished with errors");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	// Entry k of the table is (2k-5) + j(6-3k), and tap k pairs it with x[n-k].
	function automatic complexResultT referenceOutput();
		complexResultT r;
		int accRe;
		int accIm;
		accRe = 0;
		accIm = 0;
		for (int k = 0; k < LENGTH; k++) begin
			accRe += histRe[k] * (2 * k - 5) - histIm[k] * (6 - 3 * k);
			accIm += histRe[k] * (6 - 3 * k) + histIm[k] * (2 * k - 5);
		end
		r.re = accT'(accRe);
		r.im = accT'(accIm);
		return r;
	endfunction

	// One sample component in -128..127, with full scale negative forced now and then.
	function automatic int randomPart();
		int v;
		v = ($random(seed) & 255) - 128;
		if (($random(seed) & 7) == 0) v = -128;
		return v;
	endfunction

	task automatic clearHistory();
		for (int k = 0; k < LENGTH; k++) begin
			histRe[k] = 0;
			histIm[k] = 0;
		end
	endtask

	// Drives one sample strobe; the model only takes it while the filter should run.
	task automatic sendSample(input int re, input int im);
		complexSampleT s;
		s.re = sampleT'(re);
		s.im = sampleT'(im);
		@(posedge clock);
		loadDataFlag <= 1'b1;
		dataIn <= s;
		if (running) begin
			for (int k = LENGTH - 1; k > 0; k--) begin
				histRe[k] = histRe[k - 1];
				histIm[k] = histIm[k - 1];
			end
			histRe[0] = re;
			histIm[0] = im;
			expectedQ.push_back(referenceOutput());
		end
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(posedge clock);
			loadDataFlag <= 1'b0;
		end
	endtask

	task automatic waitReady(input logic want);
		int cycles;
		cycles = 0;
		do begin
			@(posedge clock);
			cycles++;
		end while (ready !== want && cycles < READY_LIMIT);
		readyReached: assert (ready === want) else reportFailure($sformatf(
			"ready did not go to %0b within %0d cycles in test %s", want, READY_LIMIT, testName));
	endtask

	task automatic waitDrained();
		int cycles;
		cycles = 0;
		while (expectedQ.size() > 0 && cycles < DRAIN_LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		allDrained: assert (expectedQ.size() == 0) else reportFailure($sformatf(
			"%0d expected results never appeared in test %s", expectedQ.size(), testName));
	endtask

	// A start also empties the model history, as the core clears its delay line.
	task automatic startRun();
		@(posedge clock);
		startFlag <= 1'b1;
		clearHistory();
		@(posedge clock);
		startFlag <= 1'b0;
		waitReady(1'b1);
		running = 1'b1;
	endtask

	task automatic stopRun();
		@(posedge clock);
		stopFlag <= 1'b1;
		running = 1'b0;
		@(posedge clock);
		stopFlag <= 1'b0;
		waitReady(1'b0);
	endtask

	// Compares each result with the oldest pending expectation.
	always @(posedge clock) begin
		if (arstN === 1'b1 && outValid === 1'b1) begin
			resultPending: assert (expectedQ.size() > 0) else reportFailure($sformatf(
				"outValid pulsed with no accepted sample pending in test %s", testName));
			expectedValue = expectedQ.pop_front();
			resultMatch: assert (dataOut === expectedValue) else reportFailure($sformatf(
				"FAILED %s expected re=%0d im=%0d actual re=%0d im=%0d", testName,
				expectedValue.re, expectedValue.im, dataOut.re, dataOut.im));
		end
	end

	initial begin
		seed = 61354;
		arstN = 1'b0;
		startFlag = 1'b0;
		stopFlag = 1'b0;
		loadDataFlag = 1'b0;
		dataIn = '0;
		running = 1'b0;
		testName = "reset";
		clearHistory();
		repeat (10) @(posedge clock);
		arstN <= 1'b1;

		// Samples before any start must be dropped, and ready must stay low.
		repeat (6) begin
			sendSample(5, -3);
			idleReady: assert (ready === 1'b0) else reportFailure(
				"ready went high before any start request");
		end
		idleCycles(3);
		testName = "start";
		startRun();

		// An impulse reads the coefficient table back in order.
		testName = "impulse";
		sendSample(1, 0);
		repeat (LENGTH - 1) sendSample(0, 0);
		idleCycles(1);
		waitDrained();

		testName = "random";
		sendSample(-128, -128);
		repeat (200) begin
			sendSample(randomPart(), randomPart());
			idleCycles($random(seed) & 3);
		end
		idleCycles(1);
		waitDrained();

		// A lost result times out the drain, and a repeated one finds no expectation.
		testName = "backToBack";
		repeat (20) sendSample(randomPart(), randomPart());
		idleCycles(1);
		waitDrained();

		// The checker flags any result that shows up while stopped.
		testName = "stop";
		stopRun();
		repeat (5) sendSample(randomPart(), randomPart());
		idleCycles(6);

		testName = "restart";
		startRun();
		repeat (12) begin
			sendSample(randomPart(), randomPart());
			idleCycles($random(seed) & 1);
		end
		idleCycles(1);
		waitDrained();

		// A few quiet cycles let any extra outValid pulse reach the checker.
		idleCycles(4);

		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
complexFirPkg.sv
coeffSource.sv
complexFirCore.sv
complexDotProduct.sv
complexFirTop.sv
tbComplexFir.sv

//--- run.sh
#!/bin/sh
# Builds the complex FIR testbench with Verilator and runs it.
# The run passes only if the pass message appears on a line of its own.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tbComplexFir -o simComplexFir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/simComplexFir)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1
